// ==== design/rv_pkg.sv ====
// Shared widths, encodings and record types for the RV32I subset hart without loads, stores or jumps
package rv_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int XLEN       = 32;   // Data and address width
    localparam int REG_ADDR_W = 5;    // x0..x31

    ////////////////////
    // Encodings
    ////////////////////

    // Major opcodes kept by this hart, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,   // R type ALU
        OPC_OP_IMM = 7'b001_0011,   // I type ALU
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_SYSTEM = 7'b111_0011    // Only ebreak is expected here
    } opcode_e;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b0001,
        ALU_AND    = 4'b0010,
        ALU_OR     = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SLL    = 4'b0101,
        ALU_SRL    = 4'b0110,
        ALU_SRA    = 4'b0111,
        ALU_SLT    = 4'b1000,
        ALU_SLTU   = 4'b1001,
        ALU_PASS_B = 4'b1010    // Operand 2 straight through, for LUI
    } alu_op_e;

    // Branch condition, signedness travels separately
    typedef enum logic [1:0] {
        BR_EQ = 2'b00,
        BR_NE = 2'b01,
        BR_LT = 2'b10,
        BR_GE = 2'b11
    } br_cond_e;

    typedef enum logic [1:0] {
        IMM_NONE = 2'b00,
        IMM_I    = 2'b01,
        IMM_B    = 2'b10,
        IMM_U    = 2'b11
    } imm_fmt_e;

    // Source of ALU operand 1
    typedef enum logic [1:0] {
        OP1_REG  = 2'b00,   // rs1 data
        OP1_ZERO = 2'b01,   // LUI
        OP1_PC   = 2'b10    // AUIPC
    } op1_sel_e;

    ////////////////////
    // Records
    ////////////////////

    // Control word from the decoder
    typedef struct packed {
        logic     reg_write;    // Write rd on this edge
        logic     alu_src;      // Operand 2 from immediate
        op1_sel_e op1_sel;
        alu_op_e  alu_op;
        logic     branch;       // Conditional branch
        logic     br_unsigned;  // bltu / bgeu
        br_cond_e br_cond;
        logic     halt;         // ebreak
        imm_fmt_e imm_fmt;
    } ctrl_t;

    // One retired instruction
    typedef struct packed {
        logic                  valid;
        logic                  halt;
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       next_pc;
        logic [REG_ADDR_W-1:0] rd_waddr;   // Zero when nothing is written
        logic [XLEN-1:0]       rd_wdata;
    } retire_t;

endpackage

// ==== design/pc_unit.sv ====
// RESET_ADDR must be word aligned and a misaligned branch target is not trapped, only flagged in simulation
`timescale 1ns/10ps

module pc_unit import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = '0
) (
    input  logic            clk,
    input  logic            rst_n,        // Synchronous, active high
    input  logic [XLEN-1:0] i_imm,        // B immediate, already sign extended
    input  logic            i_branch,
    input  logic            i_cond_true,
    input  logic            i_halt,
    output logic [XLEN-1:0] o_pc,
    output logic [XLEN-1:0] o_next_pc
);

    logic            br_taken;
    logic [XLEN-1:0] pc_q;

    assign br_taken = i_branch & i_cond_true;   // Only place the branch decision is made

    // Halt wins so the ebreak keeps retiring in place
    assign o_next_pc = i_halt   ? pc_q :
                       br_taken ? pc_q + i_imm :
                                  pc_q + XLEN'(4);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc_q <= RESET_ADDR;
        end else begin
            pc_q <= o_next_pc;
        end
    end

    assign o_pc = pc_q;   // Also the fetch address

    // A bad immediate or start address shows up here one edge later
    a_pc_aligned : assert property (@(posedge clk) disable iff (rst_n) pc_q[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc_q);

endmodule

// ==== design/decoder.sv ====
// Decodes only OP, OP_IMM, LUI, AUIPC, BRANCH and SYSTEM; anything else becomes a no-op with no write
`timescale 1ns/10ps

module decoder import rv_pkg::*; (
    input  logic [XLEN-1:0] i_inst,
    output ctrl_t           o_ctrl
);

    // Everything off, nothing written
    localparam ctrl_t CTRL_NOP = '{
        reg_write:   1'b0,
        alu_src:     1'b0,
        op1_sel:     OP1_REG,
        alu_op:      ALU_ADD,
        branch:      1'b0,
        br_unsigned: 1'b0,
        br_cond:     BR_EQ,
        halt:        1'b0,
        imm_fmt:     IMM_NONE
    };

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       f7_alt;      // funct7 bit 5, sub / sra select
    logic       imm_alt;     // Only srai uses it among immediates

    assign opcode  = opcode_e'(i_inst[6:0]);
    assign funct3  = i_inst[14:12];
    assign f7_alt  = i_inst[30];
    assign imm_alt = i_inst[30] & (funct3 == 3'b101);   // addi has no subtract form

    // funct3 to ALU operation, shared by R and I types
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        o_ctrl = CTRL_NOP;
        case (opcode)
            OPC_OP: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_op    = alu_from_funct(funct3, f7_alt);
            end
            OPC_OP_IMM: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.imm_fmt   = IMM_I;
                o_ctrl.alu_op    = alu_from_funct(funct3, imm_alt);
            end
            OPC_LUI: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.op1_sel   = OP1_ZERO;
                o_ctrl.alu_op    = ALU_PASS_B;
                o_ctrl.imm_fmt   = IMM_U;
            end
            OPC_AUIPC: begin
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 1'b1;
                o_ctrl.op1_sel   = OP1_PC;     // pc + upper immediate
                o_ctrl.imm_fmt   = IMM_U;
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches, left as no-op
                o_ctrl.branch      = (funct3[2:1] != 2'b01);
                o_ctrl.br_unsigned = funct3[1];                   // bltu, bgeu
                o_ctrl.alu_op      = funct3[1] ? ALU_SLTU : ALU_SLT;
                o_ctrl.imm_fmt     = IMM_B;
                case ({funct3[2], funct3[0]})
                    2'b00:   o_ctrl.br_cond = BR_EQ;
                    2'b01:   o_ctrl.br_cond = BR_NE;
                    2'b10:   o_ctrl.br_cond = BR_LT;   // blt, bltu
                    default: o_ctrl.br_cond = BR_GE;   // bge, bgeu
                endcase
            end
            OPC_SYSTEM: begin
                o_ctrl.halt = 1'b1;   // Treated as ebreak
            end
            default: begin
                o_ctrl = CTRL_NOP;
            end
        endcase
    end

    // A halting instruction must never touch the register file
    always_comb begin
        a_halt_no_write : assert (!(o_ctrl.halt && o_ctrl.reg_write))
            else $error("halt and reg_write both set for %h", i_inst);
    end

endmodule

// ==== design/imm_gen.sv ====
// Builds I, B and U immediates only; S and J formats are not supported by this hart
`timescale 1ns/10ps

module imm_gen import rv_pkg::*; (
    input  logic [XLEN-1:0] i_inst,
    input  imm_fmt_e        i_fmt,
    output logic [XLEN-1:0] o_imm
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;

    // I type, inst[31:20] sign extended
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};

    // B type, scattered bits and LSB forced low
    assign imm_b = {{19{i_inst[31]}},
                    i_inst[31],        // imm[12]
                    i_inst[7],         // imm[11]
                    i_inst[30:25],     // imm[10:5]
                    i_inst[11:8],      // imm[4:1]
                    1'b0};

    // U type, upper 20 bits with low 12 cleared
    assign imm_u = {i_inst[31:12], 12'b0};

    always_comb begin
        case (i_fmt)
            IMM_I:   o_imm = imm_i;
            IMM_B:   o_imm = imm_b;
            IMM_U:   o_imm = imm_u;
            default: o_imm = '0;   // R type and SYSTEM
        endcase
    end

endmodule

// ==== design/regfile.sv ====
// Reads are combinational with no write bypass; a read in the writing cycle returns the old value
`timescale 1ns/10ps

module regfile import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,        // Synchronous, active high
    input  logic [REG_ADDR_W-1:0] i_rs1_raddr,
    input  logic [REG_ADDR_W-1:0] i_rs2_raddr,
    input  logic [REG_ADDR_W-1:0] i_rd_waddr,
    input  logic                  i_rd_wen,
    input  logic [XLEN-1:0]       i_rd_wdata,
    output logic [XLEN-1:0]       o_rs1_rdata,
    output logic [XLEN-1:0]       o_rs2_rdata
);

    logic [XLEN-1:0] regs [32];   // x0 entry cleared by reset, never written

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_wen && (i_rd_waddr != '0)) begin
            regs[i_rd_waddr] <= i_rd_wdata;   // Writes to x0 dropped
        end
    end

    // x0 comes from its cleared entry
    assign o_rs1_rdata = regs[i_rs1_raddr];
    assign o_rs2_rdata = regs[i_rs2_raddr];

    ////////////////////
    // Checks
    ////////////////////

    // Holds even after an instruction has targeted x0 on an earlier edge
    a_x0_zero : assert property (@(posedge clk) disable iff (rst_n)
        ((i_rs1_raddr == '0) |-> (o_rs1_rdata == '0)) and
        ((i_rs2_raddr == '0) |-> (o_rs2_rdata == '0)))
        else $error("x0 read back non-zero");

endmodule

// ==== design/alu.sv ====
// Shift amount is the low 5 bits of operand 2; SLT/SLTU results ignore i_br_unsigned
`timescale 1ns/10ps

module alu import rv_pkg::*; (
    input  alu_op_e         i_op,
    input  logic            i_br_unsigned,
    input  br_cond_e        i_br_cond,
    input  logic [XLEN-1:0] i_op1,
    input  logic [XLEN-1:0] i_op2,
    output logic [XLEN-1:0] o_result,
    output logic            o_cond_true
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;      // Signed less than
    logic       lt_u;      // Unsigned less than
    logic       lt_br;     // Less than for the branch

    assign shamt = i_op2[4:0];

    ////////////////////
    // Compares
    ////////////////////
    assign eq    = (i_op1 == i_op2);
    assign lt_s  = ($signed(i_op1) < $signed(i_op2));
    assign lt_u  = (i_op1 < i_op2);
    assign lt_br = i_br_unsigned ? lt_u : lt_s;

    ////////////////////
    // Result
    ////////////////////
    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_op1 + i_op2;    // Carry out dropped
            ALU_SUB:    o_result = i_op1 - i_op2;
            ALU_AND:    o_result = i_op1 & i_op2;
            ALU_OR:     o_result = i_op1 | i_op2;
            ALU_XOR:    o_result = i_op1 ^ i_op2;
            ALU_SLL:    o_result = i_op1 << shamt;
            ALU_SRL:    o_result = i_op1 >> shamt;
            ALU_SRA:    o_result = $unsigned($signed(i_op1) >>> shamt);
            ALU_SLT:    o_result = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:   o_result = {{(XLEN-1){1'b0}}, lt_u};
            ALU_PASS_B: o_result = i_op2;            // LUI
            default:    o_result = '0;
        endcase
    end

    // Branch condition
    always_comb begin
        case (i_br_cond)
            BR_EQ:   o_cond_true = eq;
            BR_NE:   o_cond_true = ~eq;
            BR_LT:   o_cond_true = lt_br;
            default: o_cond_true = ~lt_br;   // BGE, BGEU
        endcase
    end

endmodule

// ==== design/hart_core.sv ====
// Single-cycle RV32I subset hart with a combinational instruction port and no stall or trap support
`timescale 1ns/10ps

module hart_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_ADDR = 32'h0000_0000   // Must be word aligned
) (
    input  logic            clk,
    input  logic            rst_n,          // Synchronous, active high
    input  logic [XLEN-1:0] i_imem_rdata,   // Same-cycle instruction word
    output logic [XLEN-1:0] o_imem_raddr,
    output retire_t         o_retire
);

    ctrl_t           ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_rdata;
    logic [XLEN-1:0] rs2_rdata;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] alu_result;
    logic            cond_true;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;

    assign rs1_addr = i_imem_rdata[19:15];
    assign rs2_addr = i_imem_rdata[24:20];
    assign rd_addr  = i_imem_rdata[11:7];

    ////////////////////
    // Fetch
    ////////////////////
    pc_unit #(.RESET_ADDR(RESET_ADDR)) pc_unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_imm      (imm),
        .i_branch   (ctrl.branch),
        .i_cond_true(cond_true),
        .i_halt     (ctrl.halt),
        .o_pc       (pc),
        .o_next_pc  (next_pc)
    );

    assign o_imem_raddr = pc;

    ////////////////////
    // Decode and read
    ////////////////////
    decoder decoder_i (.i_inst(i_imem_rdata), .o_ctrl(ctrl));

    imm_gen imm_gen_i (.i_inst(i_imem_rdata), .i_fmt(ctrl.imm_fmt), .o_imm(imm));

    regfile regfile_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1_raddr(rs1_addr),
        .i_rs2_raddr(rs2_addr),
        .i_rd_waddr (rd_addr),
        .i_rd_wen   (ctrl.reg_write),
        .i_rd_wdata (alu_result),   // No load path, ALU is the only source
        .o_rs1_rdata(rs1_rdata),
        .o_rs2_rdata(rs2_rdata)
    );

    ////////////////////
    // Execute
    ////////////////////
    always_comb begin
        case (ctrl.op1_sel)
            OP1_ZERO: op1 = '0;
            OP1_PC:   op1 = pc;
            default:  op1 = rs1_rdata;
        endcase
    end

    assign op2 = ctrl.alu_src ? imm : rs2_rdata;   // Branches compare registers

    alu alu_i (
        .i_op         (ctrl.alu_op),
        .i_br_unsigned(ctrl.br_unsigned),
        .i_br_cond    (ctrl.br_cond),
        .i_op1        (op1),
        .i_op2        (op2),
        .o_result     (alu_result),
        .o_cond_true  (cond_true)
    );

    // Retire record, combinational from the current instruction
    assign o_retire.valid    = ~rst_n;
    assign o_retire.halt     = ctrl.halt;
    assign o_retire.inst     = i_imem_rdata;
    assign o_retire.pc       = pc;
    assign o_retire.next_pc  = next_pc;
    assign o_retire.rd_waddr = ctrl.reg_write ? rd_addr : '0;
    assign o_retire.rd_wdata = alu_result;

endmodule

// ==== test/tb_program.svh ====
// Program starts at the cursor, assumes x1 negative and x2 positive, taken branches jump +8
task automatic build_program();
    logic [11:0] ra;   // Random negative immediate
    logic [11:0] rb;   // Random positive immediate
    logic [19:0] ru;   // Random upper immediate
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  sh;
    ra = 12'($urandom) | 12'h800;
    rb = 12'($urandom) & 12'h7ff;
    ru = 20'($urandom);
    a  = {{20{ra[11]}}, ra};
    b  = {20'b0, rb};
    sh = b[4:0];   // Shift amount from x2

    alu_row("addi a", encode_i(3'b000, 5'd1, 5'd0, ra), 5'd1, a);
    alu_row("addi b", encode_i(3'b000, 5'd2, 5'd0, rb), 5'd2, b);
    alu_row("add", encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, a + b);
    alu_row("sub", encode_r(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, a - b);
    alu_row("sll", encode_r(7'h00, 3'b001, 5'd5, 5'd2, 5'd2), 5'd5, b << sh);
    alu_row("slt", encode_r(7'h00, 3'b010, 5'd6, 5'd1, 5'd2), 5'd6, 32'd1);    // Negative < positive
    alu_row("sltu", encode_r(7'h00, 3'b011, 5'd7, 5'd1, 5'd2), 5'd7, 32'd0);   // Huge unsigned
    alu_row("xor", encode_r(7'h00, 3'b100, 5'd8, 5'd1, 5'd2), 5'd8, a ^ b);
    alu_row("srl", encode_r(7'h00, 3'b101, 5'd9, 5'd1, 5'd2), 5'd9, a >> sh);
    alu_row("sra", encode_r(7'h20, 3'b101, 5'd10, 5'd1, 5'd2), 5'd10, 32'($signed(a) >>> sh));
    alu_row("or", encode_r(7'h00, 3'b110, 5'd11, 5'd1, 5'd2), 5'd11, a | b);
    alu_row("and", encode_r(7'h00, 3'b111, 5'd12, 5'd1, 5'd2), 5'd12, a & b);
    alu_row("sub dep", encode_r(7'h20, 3'b000, 5'd13, 5'd3, 5'd2), 5'd13, a);   // Reads back x3
    alu_row("srai", encode_i(3'b101, 5'd14, 5'd1, {7'h20, 5'd3}), 5'd14, 32'($signed(a) >>> 3));
    alu_row("slti", encode_i(3'b010, 5'd15, 5'd2, 12'hfff), 5'd15, 32'd0);
    alu_row("sltiu", encode_i(3'b011, 5'd16, 5'd2, 12'hfff), 5'd16, 32'd1);
    alu_row("xori", encode_i(3'b100, 5'd17, 5'd1, 12'hfff), 5'd17, ~a);
    alu_row("andi", encode_i(3'b111, 5'd18, 5'd1, 12'h0f0), 5'd18, a & 32'h0000_00f0);
    alu_row("slli", encode_i(3'b001, 5'd19, 5'd2, 12'd4), 5'd19, b << 4);
    alu_row("srli", encode_i(3'b101, 5'd20, 5'd1, 12'd28), 5'd20, a >> 28);
    alu_row("addi x0", encode_i(3'b000, 5'd0, 5'd1, 12'd5), 5'd0, 32'd0);   // Write dropped
    alu_row("add x0", encode_r(7'h00, 3'b000, 5'd21, 5'd0, 5'd2), 5'd21, b);
    alu_row("lui", encode_u(7'b011_0111, 5'd22, ru), 5'd22, {ru, 12'b0});
    alu_row("auipc", encode_u(7'b001_0111, 5'd23, ru), 5'd23, cursor + {ru, 12'b0});

    // x21 equals x2 from here on
    branch_row("beq taken", 3'b000, 5'd2, 5'd21, 1'b1);
    branch_row("beq not taken", 3'b000, 5'd1, 5'd2, 1'b0);
    branch_row("bne taken", 3'b001, 5'd1, 5'd2, 1'b1);
    branch_row("bne not taken", 3'b001, 5'd2, 5'd21, 1'b0);
    branch_row("blt taken", 3'b100, 5'd1, 5'd2, 1'b1);
    branch_row("blt not taken", 3'b100, 5'd2, 5'd1, 1'b0);
    branch_row("bge taken", 3'b101, 5'd2, 5'd1, 1'b1);
    branch_row("bge not taken", 3'b101, 5'd1, 5'd2, 1'b0);
    branch_row("bltu taken", 3'b110, 5'd2, 5'd1, 1'b1);
    branch_row("bltu not taken", 3'b110, 5'd1, 5'd2, 1'b0);
    branch_row("bgeu taken", 3'b111, 5'd1, 5'd2, 1'b1);
    branch_row("bgeu not taken", 3'b111, 5'd2, 5'd1, 1'b0);

    add_row("ebreak", 32'h0010_0073, 5'd0, 32'd0, cursor, 1'b1);   // PC holds
endtask

// ==== test/tb_hart.sv ====
// Instruction memory covers byte addresses 0 to 1023 only; rd_wdata is checked only where rd is written
`timescale 1ns/10ps

module tb_hart import rv_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_ADDR = 32'h0000_0100;
    localparam int IMEM_WORDS = 256;
    localparam int SEED       = 85987;

    // One expected retire record
    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       next_pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
        logic                  halt;
    } exp_t;

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] imem_rdata;
    logic [XLEN-1:0] imem_raddr;
    retire_t         retire;

    logic [XLEN-1:0] imem [IMEM_WORDS];
    exp_t            exp_q [$];
    string           name_q [$];
    logic [XLEN-1:0] cursor;        // Build address of the next instruction
    int              errors;
    int              cycles = 0;

    hart_core #(.RESET_ADDR(RESET_ADDR)) hart_core_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_imem_rdata(imem_rdata),
        .o_imem_raddr(imem_raddr),
        .o_retire    (retire)
    );

    assign imem_rdata = imem[imem_raddr[9:2]];   // Same-cycle read, word index

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Limit grows with the table, reset cycles fit in the margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2 * exp_q.size() + 20) begin
            $display("*** FAILED ***");
            $fatal(1, "Timeout after %0d cycles, the halt instruction never retired", cycles);
        end
    end

    ////////////////////
    // Encoders
    ////////////////////
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b011_0011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b001_0011};
    endfunction

    function automatic logic [31:0] encode_u(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] encode_b(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b110_0011};
    endfunction

    ////////////////////
    // Table building
    ////////////////////
    task automatic add_row(input string name, input logic [31:0] inst, input logic [4:0] rd,
                           input logic [31:0] wdata, input logic [31:0] next_pc,
                           input logic halt);
        exp_t row;
        imem[cursor[9:2]] = inst;
        row = '{inst: inst, pc: cursor, next_pc: next_pc, rd: rd, wdata: wdata, halt: halt};
        exp_q.push_back(row);
        name_q.push_back(name);
        cursor = cursor + 32'd4;   // Layout stays sequential, branches skip over slots
    endtask

    task automatic alu_row(input string name, input logic [31:0] inst, input logic [4:0] rd,
                           input logic [31:0] wdata);
        add_row(name, inst, rd, wdata, cursor + 32'd4, 1'b0);
    endtask

    // A taken branch lands past one instruction that must never retire
    task automatic branch_row(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic taken);
        add_row(name, encode_b(f3, rs1, rs2, 13'd8), 5'd0, 32'd0,
                taken ? cursor + 32'd8 : cursor + 32'd4, 1'b0);
        if (taken) begin
            imem[cursor[9:2]] = encode_i(3'b000, 5'd24, 5'd0, 12'h7ff);
            cursor = cursor + 32'd4;
        end
    endtask

    `include "tb_program.svh"

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        void'($urandom(SEED));
        rst_n  = 1'b1;
        errors = 0;
        cursor = RESET_ADDR;
        for (int w = 0; w < IMEM_WORDS; w++) begin
            imem[w] = ~(32'(w) << 2);   // Inverted byte address
        end
        build_program();

        repeat (4) begin
            @(posedge clk);
            #2;
            check_value("reset valid", 32'd0, 32'(retire.valid));
        end
        rst_n = 1'b0;   // Released 2 ns after the fourth edge

        // Rows retire in table order, sampled mid-cycle
        foreach (exp_q[i]) begin
            @(negedge clk);
            check_value({name_q[i], " valid"}, 32'd1, 32'(retire.valid));
            check_value({name_q[i], " inst"}, exp_q[i].inst, retire.inst);
            check_value({name_q[i], " pc"}, exp_q[i].pc, retire.pc);
            check_value({name_q[i], " imem_raddr"}, exp_q[i].pc, imem_raddr);
            check_value({name_q[i], " next_pc"}, exp_q[i].next_pc, retire.next_pc);
            check_value({name_q[i], " rd_waddr"}, 32'(exp_q[i].rd), 32'(retire.rd_waddr));
            check_value({name_q[i], " halt"}, 32'(exp_q[i].halt), 32'(retire.halt));
            if (exp_q[i].rd != 5'd0) begin
                check_value({name_q[i], " rd_wdata"}, exp_q[i].wdata, retire.rd_wdata);
            end
        end

        if (errors == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

// ==== files.f ====
+incdir+test
design/rv_pkg.sv
design/pc_unit.sv
design/decoder.sv
design/imm_gen.sv
design/regfile.sv
design/alu.sv
design/hart_core.sv
test/tb_hart.sv

// ==== Makefile ====
# Verilator build and run for the single-cycle hart
VERILATOR ?= verilator
TOP       ?= tb_hart
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
